/* testbench/rhs_input.txt */
// expected configuration command words of slots 0 to 17, one hex word per line
// then the run count, then one run per line: mode (0 config, 1 zcheck, 2 both) channel scale
80200000
80210000
8026FFFF
6A000000
80000112
80010080
80020000
80030000
80040016
80050017
800600A8
8007000A
8008FFFF
800A0000
800CFFFF
802A0000
802E0000
80300000
4
0 00 0
1 05 2
2 2b 1
1 3e 3

/* sources.f */
src/rhs_pkg.sv
src/rhs_cmd_sequencer.sv
src/rhs_cmd_fifo.sv
src/rhs_spi_engine.sv
src/rhs_sample_collector.sv
src/rhs_array_ctrl.sv
testbench/rhs_array_sva.sv
testbench/tb_rhs_array.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rhs_array
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_rhs_array.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rhs_array;

    localparam int STIM_WORDS   = 31;       // 18 config words, run count, 4 runs of 3 words
    localparam int RUNS_AT      = rhs_pkg::CONFIG_WRITES;
    localparam int LOG_FRAMES   = 160;
    localparam int RUN_TIMEOUT  = 40000;    // in clk cycles against about 18500 for the longest run
    localparam int ZCHECK_TOTAL = rhs_pkg::SLOTS_PER_RUN +
                                  rhs_pkg::ZCHECK_SLOTS_PER_PERIOD * rhs_pkg::ZCHECK_SAMPLES;

    logic                           clk;
    logic                           rstn;
    logic                           config_start;
    logic                           zcheck_start;
    logic [5:0]                     zcheck_channel;
    logic [1:0]                     zcheck_scale;
    logic                           cs;
    logic                           sclk;
    logic [rhs_pkg::CHIP_COUNT-1:0] mosi;
    logic [rhs_pkg::CHIP_COUNT-1:0] miso = '0;
    rhs_pkg::zcheck_samples_t       zcheck_data;
    logic                           busy;
    logic                           done;

    logic [31:0] stim [STIM_WORDS];
    logic [15:0] base [rhs_pkg::CHIP_COUNT];       // per chip reply offset
    logic [31:0] out_sr [rhs_pkg::CHIP_COUNT];
    logic [31:0] in_sr [rhs_pkg::CHIP_COUNT];
    logic [31:0] frame_log [LOG_FRAMES][rhs_pkg::CHIP_COUNT];
    logic        cs_q = 1'b1;
    logic        sclk_q = 1'b0;
    int          frame_count = 0;
    int          done_count = 0;
    int          run_first;      // frame_count at the start of the current run
    int          value_errors;
    int          other_errors;
    logic        hung;
    integer      seed;

    rhs_array_ctrl dut (
        .clk            (clk),
        .rstn           (rstn),
        .config_start   (config_start),
        .zcheck_start   (zcheck_start),
        .zcheck_channel (zcheck_channel),
        .zcheck_scale   (zcheck_scale),
        .cs             (cs),
        .sclk           (sclk),
        .mosi           (mosi),
        .miso           (miso),
        .zcheck_data    (zcheck_data),
        .busy           (busy),
        .done           (done)
    );

    bind rhs_array_ctrl rhs_array_sva u_sva (
        .clk          (clk),
        .rstn         (rstn),
        .config_start (config_start),
        .zcheck_start (zcheck_start),
        .cs           (cs),
        .sclk         (sclk),
        .mosi         (mosi),
        .busy         (busy),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // chip n of a run answers with its base plus n in the upper half
    function automatic logic [31:0] reply_word(input int chip, input int n);
        logic [15:0] upper;
        upper = base[chip] + 16'(n);
        return {upper, 8'(chip), 8'(n)};
    endfunction

    // models of the four chips that see the sclk edges through the clk
    always @(posedge clk) begin
        logic [31:0] w;
        int          rel;
        cs_q   <= cs;
        sclk_q <= sclk;
        rel    = frame_count - run_first;
        for (int c = 0; c < rhs_pkg::CHIP_COUNT; c++) begin
            w = reply_word(c, rel);
            if (!cs && cs_q) begin               // frame start, present msb
                out_sr[c] <= w;
                miso[c]   <= w[31];
            end else if (!cs && sclk && !sclk_q) begin
                in_sr[c] <= {in_sr[c][30:0], mosi[c]};
            end else if (!cs && !sclk && sclk_q) begin
                miso[c]   <= out_sr[c][30];
                out_sr[c] <= {out_sr[c][30:0], 1'b0};
            end
            if (cs && !cs_q && rel < LOG_FRAMES) begin
                frame_log[rel][c] <= in_sr[c];
            end
        end
        if (cs && !cs_q) begin
            frame_count <= frame_count + 1;
        end
    end

    always @(posedge clk) begin
        if (rstn && done) begin
            done_count <= done_count + 1;
        end
    end

    function automatic logic [7:0] sine_value(input int step);
        real v;
        v = 128.0 + 127.0 * $sin(2.0 * 3.14159265358979 * step / 20.0);
        return 8'($rtoi(v + 0.5));
    endfunction

    task automatic check_cmd(input string name, input rhs_pkg::rhs_cmd_u got,
                             input rhs_pkg::rhs_cmd_u exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_samples(input string name, input rhs_pkg::zcheck_samples_t got,
                                 input rhs_pkg::zcheck_samples_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic wait_for_busy(input int limit);
        int t;
        t = 0;
        while (!busy && t < limit) begin
            @(negedge clk);
            t++;
        end
        if (!busy) begin
            $display("busy did not rise after an accepted start");
            other_errors++;
            hung = 1'b1;
        end
    endtask

    task automatic wait_for_frames(input int count, input int limit);
        int t;
        t = 0;
        while ((frame_count - run_first) < count && t < limit) begin
            @(negedge clk);
            t++;
        end
        if ((frame_count - run_first) < count) begin
            $display("timed out waiting for %0d frames of the run", count);
            other_errors++;
            hung = 1'b1;
        end
    endtask

    task automatic wait_for_done(input int limit);
        int t;
        t = 0;
        while (!done && t < limit) begin
            @(negedge clk);
            t++;
        end
        if (!done) begin
            $display("timed out waiting for done after %0d cycles", limit);
            other_errors++;
            hung = 1'b1;
        end
    endtask

    task automatic check_frames(input logic zmode, input logic [5:0] chan,
                                input logic [1:0] scale, input int total);
        rhs_pkg::rhs_cmd_u dummy;
        rhs_pkg::rhs_cmd_u exp;
        int                step;
        int                sub;
        dummy             = '0;
        dummy.regs.kind   = rhs_pkg::CMD_READ;
        dummy.regs.u_flag = 1'b1;
        dummy.regs.addr   = 8'd255;
        for (int n = 0; n < total; n++) begin
            for (int c = 1; c < rhs_pkg::CHIP_COUNT; c++) begin
                check_cmd($sformatf("mosi[%0d] frame %0d", c, n), frame_log[n][c],
                          frame_log[n][0]);
            end
            exp = dummy;
            if (!zmode) begin
                if (n < rhs_pkg::CONFIG_WRITES) exp = stim[n];
            end else if (n < rhs_pkg::SLOTS_PER_RUN) begin
                if (n < 2) begin
                    exp           = '0;
                    exp.regs.kind = rhs_pkg::CMD_WRITE;
                    exp.regs.addr = (n == 0) ? 8'd2 : 8'd3;
                    if (n == 0) begin  // channel, scale, enable and dac power
                        exp.regs.data = {2'b00, chan % 6'd16, 8'h41} | {11'd0, scale, 3'd0};
                    end
                end
            end else begin
                step = (n - rhs_pkg::SLOTS_PER_RUN) / rhs_pkg::ZCHECK_SLOTS_PER_PERIOD;
                sub  = (n - rhs_pkg::SLOTS_PER_RUN) % rhs_pkg::ZCHECK_SLOTS_PER_PERIOD;
                if (sub == 0) begin
                    exp           = '0;
                    exp.regs.kind = rhs_pkg::CMD_WRITE;
                    exp.regs.addr = 8'd3;
                    exp.regs.data = {8'h00, sine_value(step)};
                end else if (sub == 1) begin
                    exp              = '0;
                    exp.conv.kind    = rhs_pkg::CMD_CONVERT;
                    exp.conv.channel = chan % 6'd16;
                end
            end
            check_cmd($sformatf("mosi frame %0d", n), frame_log[n][0], exp);
        end
    endtask

    task automatic run_one(input logic [31:0] mode, input logic [31:0] chan,
                           input logic [31:0] scale);
        rhs_pkg::zcheck_samples_t exp_s;
        logic                     zmode;
        int                       total;
        int                       dones;
        int                       chip;
        zmode = (mode == 32'd1);    // mode 2 strobes both and config wins
        total = zmode ? ZCHECK_TOTAL : rhs_pkg::SLOTS_PER_RUN;
        chip  = int'(chan[5:4]);
        @(posedge clk);
        run_first = frame_count;
        dones     = done_count;
        zcheck_channel <= chan[5:0];
        zcheck_scale   <= scale[1:0];
        config_start   <= (mode != 32'd1);
        zcheck_start   <= (mode != 32'd0);
        @(posedge clk);
        config_start <= 1'b0;
        zcheck_start <= 1'b0;
        wait_for_busy(4);
        if (!hung) wait_for_frames(3, 2000);
        if (!hung) begin
            @(posedge clk);
            config_start <= 1'b1;   // must be ignored while busy
            zcheck_start <= 1'b1;
            @(posedge clk);
            config_start <= 1'b0;
            zcheck_start <= 1'b0;
            wait_for_done(RUN_TIMEOUT);
        end
        if (!hung) begin
            check_flag("busy", busy, 1'b0);
            repeat (20) @(negedge clk);
            check_count("frame count", frame_count - run_first, total);
            check_count("done pulses", done_count - dones, 1);
            check_frames(zmode, chan[5:0], scale[1:0], total);
            if (zmode) begin
                for (int k = 0; k < rhs_pkg::ZCHECK_SAMPLES; k++) begin
                    exp_s[k] = base[chip] + 16'(rhs_pkg::SLOTS_PER_RUN +
                               rhs_pkg::ZCHECK_SLOTS_PER_PERIOD * k + 3);
                end
                check_samples("zcheck_data", zcheck_data, exp_s);
            end
        end
    endtask

    initial begin
        rstn           = 1'b0;
        config_start   = 1'b0;
        zcheck_start   = 1'b0;
        zcheck_channel = 6'd0;
        zcheck_scale   = 2'd0;
        run_first      = 0;
        value_errors   = 0;
        other_errors   = 0;
        hung           = 1'b0;
        seed           = 32'hed22;
        for (int c = 0; c < rhs_pkg::CHIP_COUNT; c++) begin
            base[c] = 16'($random(seed));
        end
        $readmemh("testbench/rhs_input.txt", stim);
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        repeat (2) @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("cs", cs, 1'b1);
        check_flag("sclk", sclk, 1'b0);
        repeat (20) @(negedge clk);  // nothing may start on its own
        check_count("frames before start", frame_count, 0);
        for (int r = 0; r < int'(stim[RUNS_AT]); r++) begin
            if (!hung) begin
                run_one(stim[RUNS_AT + 1 + 3 * r], stim[RUNS_AT + 2 + 3 * r],
                        stim[RUNS_AT + 3 + 3 * r]);
            end
        end
        $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errors, other_errors, dut.u_sva.failures);
        if (value_errors == 0 && other_errors == 0 && dut.u_sva.failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/rhs_array_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module rhs_array_sva (
    input logic                           clk,
    input logic                           rstn,
    input logic                           config_start,
    input logic                           zcheck_start,
    input logic                           cs,
    input logic                           sclk,
    input logic [rhs_pkg::CHIP_COUNT-1:0] mosi,
    input logic                           busy,
    input logic                           done
);

    int failures = 0;

    // chip select stays low for the 32 sclk periods of one frame
    a_frame_len: assert property (@(posedge clk) disable iff (!rstn)
        $rose(cs) |-> (!$past(cs, rhs_pkg::SHIFT_CLKS) &&
                       $past(cs, rhs_pkg::SHIFT_CLKS + 1)))
        else begin
            failures++;
            $error("chip select low for the wrong number of cycles");
        end

    // mosi only changes while sclk is low
    a_mosi_setup: assert property (@(posedge clk) disable iff (!rstn)
        sclk |-> $stable(mosi))
        else begin
            failures++;
            $error("mosi changed while sclk was high");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rstn) done |=> !done)
        else begin
            failures++;
            $error("done held longer than one cycle");
        end

    a_busy_ends: assert property (@(posedge clk) disable iff (!rstn)
        done |-> (!busy && $past(busy)))
        else begin
            failures++;
            $error("done outside a run or busy still high with done");
        end

    a_start_taken: assert property (@(posedge clk) disable iff (!rstn)
        ((config_start || zcheck_start) && !busy) |=> busy)
        else begin
            failures++;
            $error("accepted start did not raise busy");
        end

    a_reset_idle: assert property (@(posedge clk) !rstn |=> (cs && !busy && !done))
        else begin
            failures++;
            $error("outputs not idle after reset");
        end

endmodule

`default_nettype wire

/* src/rhs_array_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rhs_array_ctrl (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           config_start,
    input  logic                           zcheck_start,
    input  logic [5:0]                     zcheck_channel,
    input  logic [1:0]                     zcheck_scale,
    output logic                           cs,
    output logic                           sclk,
    output logic [rhs_pkg::CHIP_COUNT-1:0] mosi,
    input  logic [rhs_pkg::CHIP_COUNT-1:0] miso,
    output rhs_pkg::zcheck_samples_t       zcheck_data,
    output logic                           busy,
    output logic                           done
);

    rhs_pkg::cmd_item_t   cmd_item;
    rhs_pkg::cmd_item_t   head;
    rhs_pkg::reply_item_t reply;
    logic                 push;
    logic                 pop;
    logic                 full;
    logic                 empty;
    logic                 reply_valid;

    rhs_cmd_sequencer u_sequencer (
        .clk            (clk),
        .rstn           (rstn),
        .config_start   (config_start),
        .zcheck_start   (zcheck_start),
        .zcheck_channel (zcheck_channel),
        .zcheck_scale   (zcheck_scale),
        .full           (full),
        .cmd_item       (cmd_item),
        .push           (push),
        .busy           (busy),
        .done           (done)
    );

    rhs_cmd_fifo u_fifo (
        .clk      (clk),
        .rstn     (rstn),
        .push     (push),
        .cmd_item (cmd_item),
        .pop      (pop),
        .head     (head),
        .empty    (empty),
        .full     (full)
    );

    rhs_spi_engine u_engine (
        .clk         (clk),
        .rstn        (rstn),
        .head        (head),
        .empty       (empty),
        .pop         (pop),
        .cs          (cs),
        .sclk        (sclk),
        .mosi        (mosi),
        .miso        (miso),
        .reply       (reply),
        .reply_valid (reply_valid)
    );

    rhs_sample_collector u_collector (
        .clk            (clk),
        .rstn           (rstn),
        .reply          (reply),
        .reply_valid    (reply_valid),
        .zcheck_channel (zcheck_channel),
        .zcheck_data    (zcheck_data),
        .done           (done)
    );

endmodule

`default_nettype wire

/* src/rhs_sample_collector.sv */
`timescale 1ns/1ps
`default_nettype none

module rhs_sample_collector (
    input  logic                     clk,
    input  logic                     rstn,
    input  rhs_pkg::reply_item_t     reply,
    input  logic                     reply_valid,
    input  logic [5:0]               zcheck_channel,
    output rhs_pkg::zcheck_samples_t zcheck_data,
    output logic                     done
);

    logic [1:0] chip_sel;  // chip that holds the zcheck channel

    assign chip_sel = 2'(zcheck_channel / 6'(rhs_pkg::CHANNELS_PER_CHIP));

    // adc result sits in the upper half of the reply word
    always_ff @(posedge clk) begin
        if (reply_valid && reply.capture) begin
            zcheck_data[reply.sample_idx] <=
                reply.data[chip_sel][rhs_pkg::FRAME_BITS-1 -: rhs_pkg::SAMPLE_BITS];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            done <= 1'b0;
        end else begin
            done <= reply_valid & reply.last;  // one pulse per run
        end
    end

endmodule

`default_nettype wire

/* src/rhs_spi_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module rhs_spi_engine (
    input  logic                            clk,
    input  logic                            rstn,
    input  rhs_pkg::cmd_item_t              head,
    input  logic                            empty,
    output logic                            pop,
    output logic                            cs,
    output logic                            sclk,
    output logic [rhs_pkg::CHIP_COUNT-1:0]  mosi,
    input  logic [rhs_pkg::CHIP_COUNT-1:0]  miso,
    output rhs_pkg::reply_item_t            reply,
    output logic                            reply_valid
);

    logic                                                active;
    logic [7:0]                                          tick;   // clk count inside a frame
    logic [7:0]                                          phase;  // position inside one sclk period
    logic                                                in_window;
    logic                                                sample_rx;
    logic                                                shift_tx;
    rhs_pkg::cmd_item_t                                  cur;
    logic [rhs_pkg::FRAME_BITS-1:0]                      tx;
    logic [rhs_pkg::CHIP_COUNT-1:0][rhs_pkg::FRAME_BITS-1:0] rx;

    assign phase     = tick % 8'(2 * rhs_pkg::SCLK_HALF);
    assign in_window = active && (tick < 8'(rhs_pkg::SHIFT_CLKS));
    assign sample_rx = in_window && (phase == 8'(rhs_pkg::SCLK_HALF));          // sclk rise
    assign shift_tx  = in_window && (phase == 8'(2 * rhs_pkg::SCLK_HALF - 1));  // before fall

    assign pop         = ~active & ~empty;
    assign cs          = ~in_window;
    assign sclk        = in_window && (phase >= 8'(rhs_pkg::SCLK_HALF));
    assign mosi        = {rhs_pkg::CHIP_COUNT{tx[rhs_pkg::FRAME_BITS-1]}};
    // the pop cycle is the first gap cycle, so the active count stops two short
    assign reply_valid = active && (tick == 8'(rhs_pkg::FRAME_CLKS - 2));

    always_comb begin
        reply.capture    = cur.capture;
        reply.last       = cur.last;
        reply.sample_idx = cur.sample_idx;
        reply.data       = rx;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            active <= 1'b0;
            tick   <= 8'd0;
        end else if (pop) begin
            active <= 1'b1;
            tick   <= 8'd0;
        end else if (reply_valid) begin
            active <= 1'b0;
        end else if (active) begin
            tick <= tick + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur <= head;
            tx  <= head.cmd;
        end else if (shift_tx) begin
            tx <= {tx[rhs_pkg::FRAME_BITS-2:0], 1'b0};  // msb first
        end
        if (sample_rx) begin
            for (int c = 0; c < rhs_pkg::CHIP_COUNT; c++) begin
                rx[c] <= {rx[c][rhs_pkg::FRAME_BITS-2:0], miso[c]};
            end
        end
    end

endmodule

`default_nettype wire

/* src/rhs_cmd_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module rhs_cmd_fifo (
    input  logic               clk,
    input  logic               rstn,
    input  logic               push,
    input  rhs_pkg::cmd_item_t cmd_item,
    input  logic               pop,
    output rhs_pkg::cmd_item_t head,
    output logic               empty,
    output logic               full
);

    rhs_pkg::cmd_item_t mem [rhs_pkg::FIFO_DEPTH];
    logic [1:0]         wr_ptr;
    logic [1:0]         rd_ptr;
    logic [2:0]         count;
    logic               do_push;
    logic               do_pop;

    assign empty   = (count == 3'd0);
    assign full    = (count == 3'(rhs_pkg::FIFO_DEPTH));
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= cmd_item;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= 2'd0;
            rd_ptr <= 2'd0;
            count  <= 3'd0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 2'd1;  // pointers wrap at depth 4
            if (do_pop)  rd_ptr <= rd_ptr + 2'd1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 3'd1;
                2'b01:   count <= count - 3'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/rhs_cmd_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module rhs_cmd_sequencer (
    input  logic                clk,
    input  logic                rstn,
    input  logic                config_start,
    input  logic                zcheck_start,
    input  logic [5:0]          zcheck_channel,
    input  logic [1:0]          zcheck_scale,
    input  logic                full,
    output rhs_pkg::cmd_item_t  cmd_item,
    output logic                push,
    output logic                busy,
    input  logic                done
);

    logic             run_q;       // run in progress until done
    logic             issuing;     // items left to push
    logic             zmode;
    logic             sine_phase;  // zcheck past its setup slots
    logic [5:0]       slot;
    logic [2:0]       sub;         // slot within one sine period
    logic [4:0]       sample;
    logic             start_ok;
    logic [5:0]       chip_chan;
    logic [15:0]      zc_ctrl;
    rhs_pkg::rhs_cmd_u dummy_read;
    rhs_pkg::rhs_cmd_u convert;

    assign busy      = run_q & ~done;
    assign start_ok  = ~busy & (config_start | zcheck_start);
    assign push      = issuing & ~full;
    assign chip_chan = zcheck_channel % 6'(rhs_pkg::CHANNELS_PER_CHIP);

    // dac power, scale and channel select with zcheck enabled
    assign zc_ctrl = {2'b00, chip_chan, 1'b0, 1'b1, 1'b0, zcheck_scale, 2'b00, 1'b1};

    assign dummy_read = rhs_pkg::reg_cmd(rhs_pkg::CMD_READ, 1'b1, rhs_pkg::CHIP_ID_REG, 16'h0000);

    always_comb begin
        convert              = '0;
        convert.conv.kind    = rhs_pkg::CMD_CONVERT;
        convert.conv.channel = chip_chan;
    end

    always_comb begin
        cmd_item = '0;
        if (!zmode) begin
            cmd_item.cmd  = rhs_pkg::config_word(slot);
            cmd_item.last = (slot == 6'(rhs_pkg::SLOTS_PER_RUN - 1));
        end else if (!sine_phase) begin
            case (slot)
                6'd0: cmd_item.cmd = rhs_pkg::reg_cmd(rhs_pkg::CMD_WRITE, 1'b0,
                                                      rhs_pkg::REG_ZCHECK_CTRL, zc_ctrl);
                6'd1: cmd_item.cmd = rhs_pkg::reg_cmd(rhs_pkg::CMD_WRITE, 1'b0,
                                                      rhs_pkg::REG_ZCHECK_DAC, 16'h0000);
                default: cmd_item.cmd = dummy_read;
            endcase
        end else begin
            case (sub)
                3'd0: cmd_item.cmd = rhs_pkg::reg_cmd(rhs_pkg::CMD_WRITE, 1'b0,
                    rhs_pkg::REG_ZCHECK_DAC,
                    {8'h00, rhs_pkg::sine_code(sample % 5'(rhs_pkg::SINE_STEPS))});
                3'd1: cmd_item.cmd = convert;
                default: cmd_item.cmd = dummy_read;
            endcase
            cmd_item.capture    = (sub == 3'(rhs_pkg::CONVERT_DELAY + 1));  // convert result slot
            cmd_item.sample_idx = sample;
            cmd_item.last       = (sub == 3'(rhs_pkg::ZCHECK_SLOTS_PER_PERIOD - 1)) &&
                                  (sample == 5'(rhs_pkg::ZCHECK_SAMPLES - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            run_q      <= 1'b0;
            issuing    <= 1'b0;
            zmode      <= 1'b0;
            sine_phase <= 1'b0;
            slot       <= 6'd0;
            sub        <= 3'd0;
            sample     <= 5'd0;
        end else begin
            if (done) begin
                run_q <= 1'b0;
            end
            if (push) begin
                if (cmd_item.last) begin
                    issuing <= 1'b0;
                end else if (!sine_phase) begin
                    if (slot == 6'(rhs_pkg::SLOTS_PER_RUN - 1)) begin
                        slot       <= 6'd0;
                        sine_phase <= 1'b1;  // only reached in a zcheck run
                    end else begin
                        slot <= slot + 6'd1;
                    end
                end else if (sub == 3'(rhs_pkg::ZCHECK_SLOTS_PER_PERIOD - 1)) begin
                    sub    <= 3'd0;
                    sample <= sample + 5'd1;
                end else begin
                    sub <= sub + 3'd1;
                end
            end
            if (start_ok) begin
                run_q      <= 1'b1;
                issuing    <= 1'b1;
                zmode      <= ~config_start;  // config wins a tie
                sine_phase <= 1'b0;
                slot       <= 6'd0;
                sub        <= 3'd0;
                sample     <= 5'd0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/rhs_pkg.sv */
`default_nettype none

package rhs_pkg;

    localparam int CHIP_COUNT              = 4;
    localparam int CHANNELS_PER_CHIP       = 16;
    localparam int FRAME_BITS              = 32;
    localparam int SAMPLE_BITS             = 16;
    localparam int SLOTS_PER_RUN           = 40;   // 34 converts plus 6 spare slots per sample
    localparam int CONFIG_WRITES           = 18;
    localparam int ZCHECK_SLOTS_PER_PERIOD = 5;
    localparam int SINE_STEPS              = 20;   // 1 khz sine stepped at 20 ks/s
    localparam int ZCHECK_CYCLES           = 1;
    localparam int ZCHECK_SAMPLES          = SINE_STEPS * ZCHECK_CYCLES;
    localparam int CONVERT_DELAY           = 2;    // adc result comes back two frames later
    localparam int SCLK_HALF               = 2;
    localparam int CS_GAP                  = 4;
    localparam int SHIFT_CLKS              = FRAME_BITS * 2 * SCLK_HALF;
    localparam int FRAME_CLKS              = SHIFT_CLKS + CS_GAP;
    localparam int FIFO_DEPTH              = 4;

    localparam logic [7:0] REG_ZCHECK_CTRL = 8'd2;
    localparam logic [7:0] REG_ZCHECK_DAC  = 8'd3;
    localparam logic [7:0] CHIP_ID_REG     = 8'd255;  // reads back as 32

    typedef enum logic [1:0] {
        CMD_CONVERT = 2'b00,
        CMD_CLEAR   = 2'b01,
        CMD_WRITE   = 2'b10,
        CMD_READ    = 2'b11
    } cmd_kind_e;

    typedef union packed {
        struct packed {
            cmd_kind_e   kind;
            logic        u_flag;   // apply triggered registers
            logic        m_flag;   // clear compliance monitor
            logic [3:0]  pad;
            logic [7:0]  addr;
            logic [15:0] data;
        } regs;
        struct packed {
            cmd_kind_e   kind;
            logic        u_flag;
            logic        m_flag;
            logic        d_flag;   // dc low gain amp
            logic        h_flag;   // adc offset removal
            logic [3:0]  pad;
            logic [5:0]  channel;
            logic [15:0] pad_lo;
        } conv;
    } rhs_cmd_u;

    typedef struct packed {
        rhs_cmd_u   cmd;
        logic       capture;
        logic       last;
        logic [4:0] sample_idx;
    } cmd_item_t;

    typedef struct packed {
        logic                                   capture;
        logic                                   last;
        logic [4:0]                             sample_idx;
        logic [CHIP_COUNT-1:0][FRAME_BITS-1:0] data;
    } reply_item_t;

    typedef logic [ZCHECK_SAMPLES-1:0][SAMPLE_BITS-1:0] zcheck_samples_t;

    localparam rhs_cmd_u CLEAR_CAL_WORD = 32'h6A00_0000;  // rhs uses clear instead of calibrate

    function automatic rhs_cmd_u reg_cmd(input cmd_kind_e kind, input logic u_flag,
                                         input logic [7:0] addr, input logic [15:0] data);
        rhs_cmd_u c;
        c             = '0;
        c.regs.kind   = kind;
        c.regs.u_flag = u_flag;
        c.regs.addr   = addr;
        c.regs.data   = data;
        return c;
    endfunction

    function automatic rhs_cmd_u config_word(input logic [5:0] slot);
        logic [7:0]  addr;
        logic [15:0] data;
        addr = 8'd0;
        data = 16'h0000;
        if (slot >= 6'(CONFIG_WRITES)) begin
            return reg_cmd(CMD_READ, 1'b1, CHIP_ID_REG, 16'h0000);  // dummy id read
        end
        case (slot)
            6'd0:  addr = 8'd32;                           // stim enable a off
            6'd1:  addr = 8'd33;                           // stim enable b off
            6'd2:  begin addr = 8'd38; data = 16'hFFFF; end
            6'd3:  return CLEAR_CAL_WORD;
            6'd4:  data = 16'h0112;                        // adc buffer bias 4, mux bias 18
            6'd5:  begin addr = 8'd1;  data = 16'h0080; end // weak miso, unsigned adc
            6'd6:  addr = 8'd2;                            // zcheck off
            6'd7:  addr = 8'd3;
            6'd8:  begin addr = 8'd4;  data = 16'h0016; end
            6'd9:  begin addr = 8'd5;  data = 16'h0017; end // 7.5 khz upper band
            6'd10: begin addr = 8'd6;  data = 16'h00A8; end // 5 hz lower band
            6'd11: begin addr = 8'd7;  data = 16'h000A; end
            6'd12: begin addr = 8'd8;  data = 16'hFFFF; end // all ac amps on
            6'd13: addr = 8'd10;                           // fast settle open
            6'd14: begin addr = 8'd12; data = 16'hFFFF; end
            6'd15: addr = 8'd42;                           // stimulators off
            6'd16: addr = 8'd46;
            default: addr = 8'd48;                         // charge recovery dac off
        endcase
        return reg_cmd(CMD_WRITE, 1'b0, addr, data);
    endfunction

    function automatic logic [7:0] sine_code(input logic [4:0] step);
        case (step)
            5'd0, 5'd10:  return 8'h80;
            5'd1, 5'd9:   return 8'hA7;
            5'd2, 5'd8:   return 8'hCB;
            5'd3, 5'd7:   return 8'hE7;
            5'd4, 5'd6:   return 8'hF9;
            5'd5:         return 8'hFF;
            5'd11, 5'd19: return 8'h59;
            5'd12, 5'd18: return 8'h35;
            5'd13, 5'd17: return 8'h19;
            5'd14, 5'd16: return 8'h07;
            5'd15:        return 8'h01;
            default:      return 8'h00;
        endcase
    endfunction

endpackage

`default_nettype wire
